//--- ifm_settings.svh
`ifndef IFM_SETTINGS_SVH
`define IFM_SETTINGS_SVH

// Width of one feature map word
`define IFM_DATA_WIDTH 32

// Side of a square feature map and the words it holds
`define IFM_MAP_SIZE 7
`define IFM_MAP_WORDS (`IFM_MAP_SIZE * `IFM_MAP_SIZE)

// Sixteen maps spread over six groups of three lanes
`define IFM_BUFFER_COUNT 16
`define IFM_LANES 3
`define IFM_GROUP_COUNT 6

`endif

//--- ifm_pkg.sv
`include "ifm_settings.svh"

package ifm_pkg;

	// One word of a feature map
	typedef logic [`IFM_DATA_WIDTH-1:0] word_t;

	// Word address inside a single map where 49 words need 6 bits
	typedef logic [$clog2(`IFM_MAP_WORDS)-1:0] map_addr_t;

	// Group select where values past the last group enable nothing
	typedef logic [$clog2(`IFM_GROUP_COUNT)-1:0] group_sel_t;

endpackage

//--- ifm_group_if.sv
`timescale 1ns/1ps

interface ifm_group_if
	import ifm_pkg::*;
();

	map_addr_t a_addr; // Write address or next-layer read address
	map_addr_t b_addr; // Previous-layer or next-layer read address
	logic a_wr;
	logic a_rd;
	logic b_rd;

	modport router
	(
		output a_addr, b_addr, a_wr, a_rd, b_rd
	);

	modport group
	(
		input a_addr, b_addr, a_wr, a_rd, b_rd
	);

endinterface

//--- ifm_dual_port_ram.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module ifm_dual_port_ram
	import ifm_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic a_wr,
	input logic a_rd,
	input logic b_rd,
	input map_addr_t a_addr,
	input map_addr_t b_addr,
	input word_t a_wdata,
	output word_t a_rdata,
	output word_t b_rdata
);

	word_t mem [`IFM_MAP_WORDS];

	always_ff @(posedge clk)
	begin
		if (a_wr)
			mem[a_addr] <= a_wdata;
	end

	// Port A output only loads on a pure read because a write wins the port
	always_ff @(posedge clk)
	begin
		if (rst)
			a_rdata <= '0;
		else if (a_rd && !a_wr)
			a_rdata <= mem[a_addr];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			b_rdata <= '0;
		else if (b_rd)
			b_rdata <= mem[b_addr]; // Old word when port A writes the same address
	end

endmodule

//--- ifm_bank_group.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module ifm_bank_group
	import ifm_pkg::*;
#(
	parameter int LANE_COUNT = 3
)
(
	input logic clk,
	input logic rst,
	ifm_group_if.group ctl,
	input word_t wdata [`IFM_LANES],
	output word_t a_rdata [`IFM_LANES],
	output word_t b_rdata [`IFM_LANES]
);

	// All lanes of a group share the addresses and enables
	for (genvar k = 0; k < `IFM_LANES; k++)
	begin : g_lane
		if (k < LANE_COUNT)
		begin : g_ram
			ifm_dual_port_ram ram_i
			(
				.clk(clk),
				.rst(rst),
				.a_wr(ctl.a_wr),
				.a_rd(ctl.a_rd),
				.b_rd(ctl.b_rd),
				.a_addr(ctl.a_addr),
				.b_addr(ctl.b_addr),
				.a_wdata(wdata[k]),
				.a_rdata(a_rdata[k]),
				.b_rdata(b_rdata[k])
			);
		end
		else
		begin : g_empty
			// No buffer behind this lane
			assign a_rdata[k] = '0;
			assign b_rdata[k] = '0;
		end
	end

endmodule

//--- ifm_port_router.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module ifm_port_router
	import ifm_pkg::*;
(
	input group_sel_t ifm_sel,
	input logic wr_en,
	input logic prev_rd_en,
	input logic next_rd_a_en,
	input logic next_rd_b_en,
	input map_addr_t wr_addr,
	input map_addr_t prev_rd_addr,
	input map_addr_t next_rd_a_addr,
	input map_addr_t next_rd_b_addr,
	ifm_group_if.router grp [`IFM_GROUP_COUNT]
);

	for (genvar g = 0; g < `IFM_GROUP_COUNT; g++)
	begin : g_route
		// Select value that makes this group the previous layer's target
		localparam group_sel_t OWN_SEL = group_sel_t'(g);

		// Select value that makes this group the next layer's source
		localparam group_sel_t NEXT_SEL = group_sel_t'((g + 1) % `IFM_GROUP_COUNT);

		logic is_cur;
		logic is_next;

		// Both compares fail for a select of six or seven
		assign is_cur = (ifm_sel == OWN_SEL);
		assign is_next = (ifm_sel == NEXT_SEL);

		assign grp[g].a_wr = is_cur & wr_en;
		assign grp[g].a_rd = is_next & next_rd_a_en;
		assign grp[g].b_rd = (is_cur & prev_rd_en) | (is_next & next_rd_b_en);

		always_comb
		begin
			if (is_cur)
			begin
				grp[g].a_addr = wr_addr;
				grp[g].b_addr = prev_rd_addr;
			end
			else if (is_next)
			begin
				grp[g].a_addr = next_rd_a_addr;
				grp[g].b_addr = next_rd_b_addr;
			end
			else
			begin
				grp[g].a_addr = '0;
				grp[g].b_addr = '0;
			end
		end
	end

endmodule

//--- ifm_output_select.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module ifm_output_select
	import ifm_pkg::*;
(
	input logic clk,
	input logic rst,
	input group_sel_t ifm_sel,
	input logic prev_rd_en,
	input logic next_rd_a_en,
	input logic next_rd_b_en,
	input word_t grp_a_rdata [`IFM_GROUP_COUNT][`IFM_LANES],
	input word_t grp_b_rdata [`IFM_GROUP_COUNT][`IFM_LANES],
	output word_t prev_rd_data [`IFM_LANES],
	output word_t next_rd_a_data [`IFM_LANES],
	output word_t next_rd_b_data [`IFM_LANES]
);

	localparam group_sel_t GROUPS = group_sel_t'(`IFM_GROUP_COUNT);
	localparam group_sel_t NO_GROUP = '1;

	group_sel_t prev_sel_q;
	group_sel_t next_a_sel_q;
	group_sel_t next_b_sel_q;

	// The next layer reads the group one behind the select and wraps at zero
	function automatic group_sel_t prior_group(input group_sel_t sel);
		if (sel == '0)
			return GROUPS - 1'b1;
		return sel - 1'b1;
	endfunction

	// Each path remembers the select of its own last read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prev_sel_q <= NO_GROUP;
			next_a_sel_q <= NO_GROUP;
			next_b_sel_q <= NO_GROUP;
		end
		else
		begin
			if (prev_rd_en)
				prev_sel_q <= ifm_sel;
			if (next_rd_a_en)
				next_a_sel_q <= ifm_sel;
			if (next_rd_b_en)
				next_b_sel_q <= ifm_sel;
		end
	end

	always_comb
	begin
		for (int k = 0; k < `IFM_LANES; k++)
		begin
			prev_rd_data[k] = '0;
			next_rd_a_data[k] = '0;
			next_rd_b_data[k] = '0;
			if (prev_sel_q < GROUPS)
				prev_rd_data[k] = grp_b_rdata[prev_sel_q][k]; // Read back on port B
			if (next_a_sel_q < GROUPS)
				next_rd_a_data[k] = grp_a_rdata[prior_group(next_a_sel_q)][k];
			if (next_b_sel_q < GROUPS)
				next_rd_b_data[k] = grp_b_rdata[prior_group(next_b_sel_q)][k];
		end
	end

endmodule

//--- ifm_buffer_array.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module ifm_buffer_array
	import ifm_pkg::*;
(
	input logic clk,
	input logic rst,
	input group_sel_t ifm_sel,
	input logic wr_en,
	input map_addr_t wr_addr,
	input word_t wr_data_0,
	input word_t wr_data_1,
	input word_t wr_data_2,
	input logic prev_rd_en,
	input map_addr_t prev_rd_addr,
	output word_t prev_rd_data_0,
	output word_t prev_rd_data_1,
	output word_t prev_rd_data_2,
	input logic next_rd_a_en,
	input map_addr_t next_rd_a_addr,
	output word_t next_rd_a_data_0,
	output word_t next_rd_a_data_1,
	output word_t next_rd_a_data_2,
	input logic next_rd_b_en,
	input map_addr_t next_rd_b_addr,
	output word_t next_rd_b_data_0,
	output word_t next_rd_b_data_1,
	output word_t next_rd_b_data_2
);

	word_t wr_data [`IFM_LANES];
	word_t grp_a_rdata [`IFM_GROUP_COUNT][`IFM_LANES];
	word_t grp_b_rdata [`IFM_GROUP_COUNT][`IFM_LANES];
	word_t prev_rd_data [`IFM_LANES];
	word_t next_rd_a_data [`IFM_LANES];
	word_t next_rd_b_data [`IFM_LANES];

	ifm_group_if grp [`IFM_GROUP_COUNT] ();

	assign wr_data[0] = wr_data_0;
	assign wr_data[1] = wr_data_1;
	assign wr_data[2] = wr_data_2;

	ifm_port_router router_i
	(
		.ifm_sel(ifm_sel),
		.wr_en(wr_en),
		.prev_rd_en(prev_rd_en),
		.next_rd_a_en(next_rd_a_en),
		.next_rd_b_en(next_rd_b_en),
		.wr_addr(wr_addr),
		.prev_rd_addr(prev_rd_addr),
		.next_rd_a_addr(next_rd_a_addr),
		.next_rd_b_addr(next_rd_b_addr),
		.grp(grp)
	);

	for (genvar g = 0; g < `IFM_GROUP_COUNT; g++)
	begin : g_group
		// The last group only holds what is left of the sixteen maps
		localparam int LANES_HERE = (g == `IFM_GROUP_COUNT - 1) ?
			`IFM_BUFFER_COUNT - g * `IFM_LANES : `IFM_LANES;

		ifm_bank_group #(.LANE_COUNT(LANES_HERE)) bank_i
		(
			.clk(clk),
			.rst(rst),
			.ctl(grp[g]),
			.wdata(wr_data),
			.a_rdata(grp_a_rdata[g]),
			.b_rdata(grp_b_rdata[g])
		);
	end

	ifm_output_select output_select_i
	(
		.clk(clk),
		.rst(rst),
		.ifm_sel(ifm_sel),
		.prev_rd_en(prev_rd_en),
		.next_rd_a_en(next_rd_a_en),
		.next_rd_b_en(next_rd_b_en),
		.grp_a_rdata(grp_a_rdata),
		.grp_b_rdata(grp_b_rdata),
		.prev_rd_data(prev_rd_data),
		.next_rd_a_data(next_rd_a_data),
		.next_rd_b_data(next_rd_b_data)
	);

	assign prev_rd_data_0 = prev_rd_data[0];
	assign prev_rd_data_1 = prev_rd_data[1];
	assign prev_rd_data_2 = prev_rd_data[2];
	assign next_rd_a_data_0 = next_rd_a_data[0];
	assign next_rd_a_data_1 = next_rd_a_data[1];
	assign next_rd_a_data_2 = next_rd_a_data[2];
	assign next_rd_b_data_0 = next_rd_b_data[0];
	assign next_rd_b_data_1 = next_rd_b_data[1];
	assign next_rd_b_data_2 = next_rd_b_data[2];

endmodule

//--- tb_ifm_buffer_array.sv
`timescale 1ns/1ps
`include "ifm_settings.svh"

module tb_ifm_buffer_array
	import ifm_pkg::*;
();

	// Roughly 1350 cycles of tests with some margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst;
	group_sel_t ifm_sel;
	logic wr_en;
	logic prev_rd_en;
	logic next_rd_a_en;
	logic next_rd_b_en;
	map_addr_t wr_addr;
	map_addr_t prev_rd_addr;
	map_addr_t next_rd_a_addr;
	map_addr_t next_rd_b_addr;
	word_t wr_data [`IFM_LANES];
	word_t prev_out [`IFM_LANES];
	word_t next_a_out [`IFM_LANES];
	word_t next_b_out [`IFM_LANES];

	word_t ref_mem [`IFM_BUFFER_COUNT][`IFM_MAP_WORDS];
	word_t exp_prev [`IFM_LANES];
	word_t exp_next_a [`IFM_LANES];
	word_t exp_next_b [`IFM_LANES];
	logic chk_prev;
	logic chk_next_a;
	logic chk_next_b;
	string chk_name;
	word_t pend_prev [`IFM_LANES];
	word_t pend_next_a [`IFM_LANES];
	word_t pend_next_b [`IFM_LANES];
	logic pend_chk_prev;
	logic pend_chk_next_a;
	logic pend_chk_next_b;
	string pend_name;
	int error_count;
	int cycle_count;

	ifm_buffer_array ifm_buffer_array_i
	(
		.clk(clk),
		.rst(rst),
		.ifm_sel(ifm_sel),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data_0(wr_data[0]),
		.wr_data_1(wr_data[1]),
		.wr_data_2(wr_data[2]),
		.prev_rd_en(prev_rd_en),
		.prev_rd_addr(prev_rd_addr),
		.prev_rd_data_0(prev_out[0]),
		.prev_rd_data_1(prev_out[1]),
		.prev_rd_data_2(prev_out[2]),
		.next_rd_a_en(next_rd_a_en),
		.next_rd_a_addr(next_rd_a_addr),
		.next_rd_a_data_0(next_a_out[0]),
		.next_rd_a_data_1(next_a_out[1]),
		.next_rd_a_data_2(next_a_out[2]),
		.next_rd_b_en(next_rd_b_en),
		.next_rd_b_addr(next_rd_b_addr),
		.next_rd_b_data_0(next_b_out[0]),
		.next_rd_b_data_1(next_b_out[1]),
		.next_rd_b_data_2(next_b_out[2])
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Expected word of one lane which is zero where no buffer exists
	function automatic word_t ref_read(input int group, input int lane, input int addr);
		int buf_idx;
		if (group >= `IFM_GROUP_COUNT)
			return '0;
		buf_idx = group * `IFM_LANES + lane;
		if (buf_idx >= `IFM_BUFFER_COUNT)
			return '0;
		return ref_mem[buf_idx][addr];
	endfunction

	// The group one behind the select feeds the next layer
	function automatic int source_group(input int sel);
		if (sel >= `IFM_GROUP_COUNT)
			return 7;
		return (sel + `IFM_GROUP_COUNT - 1) % `IFM_GROUP_COUNT;
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Captures the expected reads of this cycle before the write reaches the model
	task automatic issue(input string name);
		int buf_idx;
		for (int k = 0; k < `IFM_LANES; k++)
		begin
			exp_prev[k] = ref_read(ifm_sel, k, prev_rd_addr);
			exp_next_a[k] = ref_read(source_group(ifm_sel), k, next_rd_a_addr);
			exp_next_b[k] = ref_read(source_group(ifm_sel), k, next_rd_b_addr);
		end
		chk_prev = prev_rd_en;
		chk_next_a = next_rd_a_en;
		chk_next_b = next_rd_b_en;
		chk_name = name;
		if (wr_en && ifm_sel < `IFM_GROUP_COUNT)
		begin
			for (int k = 0; k < `IFM_LANES; k++)
			begin
				buf_idx = ifm_sel * `IFM_LANES + k;
				if (buf_idx < `IFM_BUFFER_COUNT)
					ref_mem[buf_idx][wr_addr] = wr_data[k];
			end
		end
		@(posedge clk);
		#1;
		wr_en = 1'b0;
		prev_rd_en = 1'b0;
		next_rd_a_en = 1'b0;
		next_rd_b_en = 1'b0;
	endtask

	task automatic random_write();
		wr_en = 1'b1;
		wr_addr = map_addr_t'($urandom_range(`IFM_MAP_WORDS - 1));
		for (int k = 0; k < `IFM_LANES; k++)
			wr_data[k] = $urandom;
	endtask

	task automatic random_reads();
		prev_rd_en = 1'b1;
		next_rd_a_en = 1'b1;
		next_rd_b_en = 1'b1;
		prev_rd_addr = map_addr_t'($urandom_range(`IFM_MAP_WORDS - 1));
		next_rd_a_addr = map_addr_t'($urandom_range(`IFM_MAP_WORDS - 1));
		next_rd_b_addr = map_addr_t'($urandom_range(`IFM_MAP_WORDS - 1));
	endtask

	// Expected values move one stage at the edge and are compared at the falling edge
	// after the inputs of the next cycle have already changed
	always @(posedge clk)
	begin
		pend_prev = exp_prev;
		pend_next_a = exp_next_a;
		pend_next_b = exp_next_b;
		pend_chk_prev = chk_prev;
		pend_chk_next_a = chk_next_a;
		pend_chk_next_b = chk_next_b;
		pend_name = chk_name;
		chk_prev = 1'b0;
		chk_next_a = 1'b0;
		chk_next_b = 1'b0;
		@(negedge clk);
		for (int k = 0; k < `IFM_LANES; k++)
		begin
			if (pend_chk_prev)
				check_word({pend_name, " prev"}, pend_prev[k], prev_out[k]);
			if (pend_chk_next_a)
				check_word({pend_name, " next_a"}, pend_next_a[k], next_a_out[k]);
			if (pend_chk_next_b)
				check_word({pend_name, " next_b"}, pend_next_b[k], next_b_out[k]);
		end
	end

	initial
	begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles with %0d errors, the tests did not finish",
			cycle_count, error_count);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hc191_8a0a));
		error_count = 0;
		chk_prev = 1'b0;
		chk_next_a = 1'b0;
		chk_next_b = 1'b0;
		rst = 1'b1;
		ifm_sel = '0;
		wr_en = 1'b0;
		prev_rd_en = 1'b0;
		next_rd_a_en = 1'b0;
		next_rd_b_en = 1'b0;
		wr_addr = '0;
		prev_rd_addr = '0;
		next_rd_a_addr = '0;
		next_rd_b_addr = '0;
		for (int k = 0; k < `IFM_LANES; k++)
			wr_data[k] = '0;
		for (int b = 0; b < `IFM_BUFFER_COUNT; b++)
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
				ref_mem[b][a] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int k = 0; k < `IFM_LANES; k++)
		begin
			check_word("reset prev", '0, prev_out[k]);
			check_word("reset next_a", '0, next_a_out[k]);
			check_word("reset next_b", '0, next_b_out[k]);
		end

		// Every address of every group is written once before anything reads it
		for (int g = 0; g < `IFM_GROUP_COUNT; g++)
		begin
			ifm_sel = group_sel_t'(g);
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				random_write();
				wr_addr = map_addr_t'(a);
				issue("fill_write");
			end
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				prev_rd_en = 1'b1;
				prev_rd_addr = map_addr_t'(a);
				issue("fill_read");
			end
		end

		for (int s = 0; s < `IFM_GROUP_COUNT; s++)
		begin
			ifm_sel = group_sel_t'(s);
			repeat (20)
			begin
				random_reads();
				prev_rd_en = 1'b0;
				issue("next_read");
			end
		end

		repeat (300)
		begin
			ifm_sel = group_sel_t'($urandom_range(`IFM_GROUP_COUNT - 1));
			random_write();
			random_reads();
			wr_en = $urandom_range(1);
			prev_rd_en = $urandom_range(1);
			next_rd_a_en = $urandom_range(1);
			next_rd_b_en = $urandom_range(1);
			issue("traffic");
		end

		for (int s = 0; s < `IFM_GROUP_COUNT; s++)
		begin
			ifm_sel = group_sel_t'(s);
			random_reads();
			issue("sel_change");
			ifm_sel = group_sel_t'((s + 2) % `IFM_GROUP_COUNT); // Moves while the data is in flight
			issue("sel_change");
		end

		for (int bad = 6; bad < 8; bad++)
		begin
			ifm_sel = group_sel_t'(bad);
			repeat (10)
			begin
				random_write();
				random_reads();
				issue("bad_sel");
			end
		end

		// A write under a bad select must not have reached any group
		for (int g = 0; g < `IFM_GROUP_COUNT; g++)
		begin
			ifm_sel = group_sel_t'(g);
			for (int a = 0; a < `IFM_MAP_WORDS; a++)
			begin
				prev_rd_en = 1'b1;
				prev_rd_addr = map_addr_t'(a);
				issue("bad_sel_readback");
			end
		end
		issue("drain");

		$display("checks done, %0d errors", error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+.
ifm_pkg.sv
ifm_group_if.sv
ifm_dual_port_ram.sv
ifm_bank_group.sv
ifm_port_router.sv
ifm_output_select.sv
ifm_buffer_array.sv
tb_ifm_buffer_array.sv

//--- run_sim.sh
#!/bin/sh
# Builds with Verilator and runs the testbench; the exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_ifm_buffer_array -o sim_ifm_buffer_array \
	&& ./obj_dir/sim_ifm_buffer_array | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
	&& echo "run ok" \
	|| { echo "run failed"; exit 1; }
